//--- ray_pipeline.f
verilog/ray_pkg.sv
verilog/credit_fifo.sv
verilog/slab_intersect.sv
verilog/pixel_shade.sv
verilog/frame_tracker.sv
verilog/ray_pipeline.sv
tests/ray_pipeline_tb.sv

//--- Bender.yml
package:
  name: ray_pipeline

sources:
  - verilog/ray_pkg.sv
  - verilog/credit_fifo.sv
  - verilog/slab_intersect.sv
  - verilog/pixel_shade.sv
  - verilog/frame_tracker.sv
  - verilog/ray_pipeline.sv
  - target: simulation
    files:
      - tests/ray_pipeline_tb.sv

//--- tests/ray_pipeline_tb.sv
// ray_pipeline_tb: table-driven testbench with slab/shade model, credit source and sink
module ray_pipeline_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import ray_pkg::*;

	localparam int N_ROWS = 32; // two frames
	localparam int CYCLE_LIMIT = 40 * N_ROWS + 200;

	logic clk;
	logic rst_n;
	logic ray_valid;
	ray_t ray;
	logic ray_credit;
	logic pix_valid;
	pixel_t pix;
	logic pix_credit;

	ray_t stim [N_ROWS];
	pixel_t exp_pix [N_ROWS];
	int n_rows;

	logic started;
	int cycles;
	int n_sent;
	int n_out;
	int credit_total;
	int src_credits;
	int snk_credits; // slots the sink has granted and not yet seen used
	int held; // pixels sitting in the sink
	logic [19:0] lfsr_state;

	ray_pipeline ray_pipeline_i (
		.clk,
		.rst_n,
		.ray_valid,
		.ray,
		.ray_credit,
		.pix_valid,
		.pix,
		.pix_credit
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	// x^20 + x^17 + 1
	function automatic logic [19:0] lfsr_next(input logic [19:0] s);
		return {s[18:0], s[19] ^ s[16]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[6:0], lfsr_state[0]};
		end
	endtask

	function automatic fix_t to_fix(input real v);
		return fix_t'($rtoi(v * 256.0));
	endfunction

	// hit time of one plane, Q8.8 product truncated to 16 bits
	function automatic fix_t plane_time(input fix_t bound, input fix_t org, input fix_t inv);
		int prod;
		prod = (int'(bound) - int'(org)) * int'(inv);
		return fix_t'(prod >>> 8);
	endfunction

	function automatic pixel_t expect_pixel(input ray_t r, input int idx);
		fix_t org [3];
		fix_t inv [3];
		fix_t a;
		fix_t b;
		fix_t near_t;
		fix_t far_t;
		logic hit;
		int depth;
		logic [7:0] grey;
		pixel_t p;
		org[0] = r.origin.x;
		org[1] = r.origin.y;
		org[2] = r.origin.z;
		inv[0] = r.inv_dir.x;
		inv[1] = r.inv_dir.y;
		inv[2] = r.inv_dir.z;
		near_t = '0;
		far_t = '0;
		for (int k = 0; k < 3; k++) begin
			a = plane_time(BOX_MIN, org[k], inv[k]);
			b = plane_time(BOX_MAX, org[k], inv[k]);
			if (b < a) begin
				a = b; // swap so a is entry
				b = plane_time(BOX_MIN, org[k], inv[k]);
			end
			if (k == 0 || a > near_t) near_t = a;
			if (k == 0 || b < far_t) far_t = b;
		end
		hit = (near_t <= far_t) && (far_t >= 0);
		depth = (near_t < 0) ? 0 : (int'(near_t) >>> 8);
		if (depth > 255) depth = 255;
		grey = 8'(255 - depth);
		p.pixel_id = 8'(idx % 256);
		p.rgb = hit ? {grey, grey, grey} : BG_COLOR;
		p.last = ((idx % FRAME_PIXELS) == FRAME_PIXELS - 1);
		return p;
	endfunction

	task automatic add_row(input real ox, oy, oz, ix, iy, iz);
		ray_t r;
		r.pixel_id = 8'(n_rows % 256);
		r.origin.x = to_fix(ox);
		r.origin.y = to_fix(oy);
		r.origin.z = to_fix(oz);
		r.inv_dir.x = to_fix(ix);
		r.inv_dir.y = to_fix(iy);
		r.inv_dir.z = to_fix(iz);
		stim[n_rows] = r;
		exp_pix[n_rows] = expect_pixel(r, n_rows);
		n_rows++;
	endtask

	task automatic load_table();
		n_rows = 0;
		add_row(-2.0, 0.5, 0.5, 1.0, 8.0, 8.0); // head-on +x
		add_row(3.0, 0.5, 0.5, -1.0, 8.0, 8.0);
		add_row(0.5, -3.5, 0.5, 8.0, 0.5, 8.0);
		add_row(0.5, 0.5, 4.0, -8.0, 8.0, -0.25);
		add_row(-1.0, -1.0, -1.0, 1.0, 1.0, 1.0);
		add_row(-1.0, 0.0, 0.5, 1.0, 8.0, 8.0); // grazing y faces
		add_row(-1.0, 1.0, 0.5, 1.0, 8.0, 8.0);
		add_row(-1.0, -1.0, 0.5, 1.0, 1.0, 8.0);
		add_row(-2.0, -1.0, 0.5, 1.0, 1.0, 8.0); // touches an edge
		add_row(-2.0, 0.5, 0.5, -1.0, 8.0, 8.0); // pointing away
		add_row(3.0, 0.5, 0.5, 1.0, 8.0, 8.0);
		add_row(0.5, 0.5, 0.5, 2.0, 4.0, -8.0); // starts inside
		add_row(0.25, 0.75, 0.5, -1.0, 2.0, 8.0);
		add_row(0.875, 0.125, 0.875, 8.0, -8.0, 0.5);
		add_row(-4.0, -4.0, -4.0, 0.5, 0.5, 0.5);
		add_row(4.0, 4.0, 4.0, -0.25, -0.25, -0.25);
		add_row(-3.0, 2.0, 0.5, 1.0, 8.0, 8.0); // second frame
		add_row(-3.0, 0.5, -2.0, 1.0, 8.0, 1.0);
		add_row(-3.0, 0.5, -2.5, 1.0, 8.0, 1.0);
		add_row(-3.0, 0.5, -1.0, 1.0, 8.0, 1.0);
		add_row(2.0, -2.0, 0.5, -0.5, 0.5, 8.0);
		add_row(1.5, 1.5, 1.5, -2.0, -2.0, -2.0);
		add_row(1.5, 1.5, 1.5, 2.0, 2.0, 2.0);
		add_row(-0.5, 0.5, 0.5, 8.0, -8.0, 8.0);
		add_row(0.5, 0.5, -4.0, 8.0, 8.0, 0.125);
		add_row(-4.0, 0.5, 0.5, 0.125, 8.0, 8.0);
		add_row(0.0, 0.0, 0.0, 1.0, 1.0, 1.0); // from a corner
		add_row(1.0, 1.0, 1.0, 1.0, 1.0, 1.0);
		add_row(1.0, 1.0, 1.0, -1.0, -1.0, -1.0);
		add_row(-2.0, -2.0, 0.5, 1.0, -1.0, 8.0);
		add_row(3.5, -0.5, 0.5, -4.0, 4.0, 8.0);
		add_row(-4.0, -4.0, -4.0, 2.0, 2.0, 2.0); // far hit, darker grey
	endtask

	task automatic check_output();
		pixel_t want;
		if (pix_valid) begin
			assert (snk_credits > 0)
			else stop_run("pix_valid rose while the sink had no free slot granted");
			assert (n_out < N_ROWS)
			else stop_run("more pixels came out than rays were sent");
			want = exp_pix[n_out];
			assert (pix === want)
			else stop_run($sformatf(
				"MISMATCH at %0t ns: pixel %0d got id %0d rgb %06h last %0b, want id %0d rgb %06h last %0b",
				$time, n_out, pix.pixel_id, pix.rgb, pix.last, want.pixel_id, want.rgb, want.last));
			snk_credits--;
			held++;
			n_out++;
		end
	endtask

	task automatic drive_source();
		logic [7:0] bits;
		src_credits = src_credits + (ray_credit ? 1 : 0) - (ray_valid ? 1 : 0);
		if (ray_credit) credit_total++;
		assert (src_credits >= 0 && src_credits <= RAY_QUEUE_DEPTH)
		else stop_run("ray credits returned do not match the rays sent");
		draw_bits(2, bits);
		if (src_credits > 0 && n_sent < N_ROWS && bits[1:0] != 2'b11) begin
			ray_valid <= 1'b1;
			ray <= stim[n_sent];
			n_sent++;
		end else begin
			ray_valid <= 1'b0; // pause or out of credit
		end
	endtask

	task automatic drive_sink();
		logic [7:0] bits;
		if (pix_credit) snk_credits++;
		draw_bits(1, bits);
		if (held > 0 && bits[0]) begin
			pix_credit <= 1'b1;
			held--;
		end else begin
			pix_credit <= 1'b0; // withhold
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				stop_run("timeout: the pixel stream did not finish within the cycle limit");
			end
			if (!started) begin
				assert (pix_valid === 1'b0 && ray_credit === 1'b0)
				else stop_run($sformatf("MISMATCH at %0t ns: idle outputs pix_valid %b ray_credit %b",
					$time, pix_valid, ray_credit));
			end else begin
				check_output();
				drive_source();
				drive_sink();
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		ray_valid = 1'b0;
		ray = '0;
		pix_credit = 1'b0;
		started = 1'b0;
		cycles = 0;
		n_sent = 0;
		n_out = 0;
		credit_total = 0;
		src_credits = RAY_QUEUE_DEPTH;
		snk_credits = PIX_CREDITS;
		held = 0;
		lfsr_state = 20'd98613;
		load_table();
		assert (n_rows == N_ROWS)
		else stop_run("stimulus table does not hold the expected number of rows");

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (8) @(posedge clk); // idle window after reset
		started <= 1'b1;

		wait (n_out == N_ROWS);
		repeat (20) @(posedge clk); // catch any extra pixel

		if (n_sent == N_ROWS && credit_total == N_ROWS && src_credits == RAY_QUEUE_DEPTH) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			stop_run($sformatf("MISMATCH at %0t ns: sent %0d rays, %0d ray credits, %0d held, want %0d",
				$time, n_sent, credit_total, src_credits, N_ROWS));
		end
	end

endmodule : ray_pipeline_tb

//--- verilog/ray_pipeline.sv
// ray_pipeline: ray queue, slab intersector, shader, pixel buffer and frame output
module ray_pipeline (
	input logic clk,
	input logic rst_n,
	input logic ray_valid,
	input ray_pkg::ray_t ray,
	output logic ray_credit,
	output logic pix_valid,
	output ray_pkg::pixel_t pix,
	input logic pix_credit
);

	import ray_pkg::*;

	ray_t q_ray;
	logic q_empty;
	logic ray_pop;

	logic res_valid;
	hit_t res;

	logic pb_we;
	pixel_t pb_wdata;
	logic pb_re;
	pixel_t pb_rdata;
	logic pb_empty;
	logic [PB_FREE_W-1:0] pb_free;

	assign ray_credit = ray_pop; // each dequeue frees an upstream slot

	credit_fifo #(.payload_t(ray_t), .DEPTH(RAY_QUEUE_DEPTH)) ray_q (
		.clk, .rst_n,
		.we(ray_valid), .wdata(ray),
		.re(ray_pop), .rdata(q_ray),
		.empty(q_empty), .free()
	);

	slab_intersect si (
		.clk, .rst_n,
		.q_empty, .q_ray, .pb_free,
		.ray_pop, .res_valid, .res
	);

	pixel_shade shade (
		.clk, .rst_n,
		.res_valid, .res,
		.pb_we, .pb_data(pb_wdata)
	);

	credit_fifo #(.payload_t(pixel_t), .DEPTH(PIX_BUF_DEPTH)) pix_buf (
		.clk, .rst_n,
		.we(pb_we), .wdata(pb_wdata),
		.re(pb_re), .rdata(pb_rdata),
		.empty(pb_empty), .free(pb_free)
	);

	frame_tracker ft (
		.clk, .rst_n,
		.pb_empty, .pb_data(pb_rdata), .pix_credit,
		.pb_re, .pix_valid, .pix
	);

endmodule : ray_pipeline

//--- verilog/frame_tracker.sv
// frame_tracker: spends sink credits to drain the pixel buffer and flags frame ends
module frame_tracker (
	input logic clk,
	input logic rst_n,
	input logic pb_empty,
	input ray_pkg::pixel_t pb_data,
	input logic pix_credit,
	output logic pb_re,
	output logic pix_valid,
	output ray_pkg::pixel_t pix
);

	import ray_pkg::*;

	logic [PIX_CREDIT_W-1:0] credits;
	logic [FRAME_CNT_W-1:0] pix_cnt;
	logic frame_end;

	assign pb_re = !pb_empty && (credits != '0);
	assign frame_end = (pix_cnt == FRAME_CNT_W'(FRAME_PIXELS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits <= PIX_CREDIT_W'(PIX_CREDITS);
			pix_cnt <= '0;
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= pb_re;
			if (pb_re) begin
				pix_cnt <= frame_end ? '0 : pix_cnt + 1'b1;
			end
			// a pop becomes pix_valid next cycle, so charge it now
			case ({pb_re, pix_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pb_re) begin
			pix.pixel_id <= pb_data.pixel_id;
			pix.rgb <= pb_data.rgb;
			pix.last <= frame_end;
		end
	end

endmodule : frame_tracker

//--- verilog/pixel_shade.sv
// pixel_shade: turns a slab result into a depth-grey or background pixel entry
module pixel_shade (
	input logic clk,
	input logic rst_n,
	input logic res_valid,
	input ray_pkg::hit_t res,
	output logic pb_we,
	output ray_pkg::pixel_t pb_data
);

	import ray_pkg::*;

	logic [7:0] depth; // integer part of t_near, clamped
	logic [7:0] level;

	always_comb begin
		if (res.t_near < fix_t'(0)) begin
			depth = 8'd0; // origin inside the box
		end else begin
			depth = res.t_near[15:8];
		end
		level = 8'd255 - depth; // nearer is brighter
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pb_we <= 1'b0;
		end else begin
			pb_we <= res_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (res_valid) begin
			pb_data.pixel_id <= res.pixel_id;
			pb_data.rgb <= res.hit ? {3{level}} : BG_COLOR;
			pb_data.last <= 1'b0; // set later by the frame tracker
		end
	end

endmodule : pixel_shade

//--- verilog/slab_intersect.sv
// slab_intersect: issue gate and 3-stage ray/box slab test, one ray per cycle
module slab_intersect (
	input logic clk,
	input logic rst_n,
	input logic q_empty,
	input ray_pkg::ray_t q_ray,
	input logic [ray_pkg::PB_FREE_W-1:0] pb_free,
	output logic ray_pop,
	output logic res_valid,
	output ray_pkg::hit_t res
);

	import ray_pkg::*;

	// distance to one slab plane: (bound - org) * inv, Q8.8 result
	function automatic fix_t slab_dist(fix_t bound, fix_t org, fix_t inv);
		fix_t d;
		logic signed [31:0] p;
		d = bound - org;
		p = d * inv;
		return fix_t'(p >>> 8);
	endfunction

	// pop history, bit k = ray popped k+1 cycles ago
	// bits 0..2 double as the stage valids
	logic [ISSUE_LATENCY-1:0] iss_sr;
	logic [PB_FREE_W-1:0] in_flight;

	logic [PIX_ID_W-1:0] s1_id;
	fix_t s1_t0 [3];
	fix_t s1_t1 [3];

	logic [PIX_ID_W-1:0] s2_id;
	fix_t s2_lo [3];
	fix_t s2_hi [3];

	fix_t t_near;
	fix_t t_far;

	// rays not yet visible in pb_free
	always_comb begin
		in_flight = '0;
		for (int i = 0; i < ISSUE_LATENCY; i++) begin
			in_flight = in_flight + iss_sr[i];
		end
	end

	// reserve a pixel buffer slot for every ray in flight
	assign ray_pop = !q_empty && (pb_free > in_flight);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			iss_sr <= '0;
		end else begin
			iss_sr <= {iss_sr[ISSUE_LATENCY-2:0], ray_pop};
		end
	end

	// stage 1: plane distances per axis
	always_ff @(posedge clk) begin
		s1_id <= q_ray.pixel_id;
		s1_t0[0] <= slab_dist(BOX_MIN, q_ray.origin.x, q_ray.inv_dir.x);
		s1_t1[0] <= slab_dist(BOX_MAX, q_ray.origin.x, q_ray.inv_dir.x);
		s1_t0[1] <= slab_dist(BOX_MIN, q_ray.origin.y, q_ray.inv_dir.y);
		s1_t1[1] <= slab_dist(BOX_MAX, q_ray.origin.y, q_ray.inv_dir.y);
		s1_t0[2] <= slab_dist(BOX_MIN, q_ray.origin.z, q_ray.inv_dir.z);
		s1_t1[2] <= slab_dist(BOX_MAX, q_ray.origin.z, q_ray.inv_dir.z);
	end

	// stage 2: order entry/exit per axis
	always_ff @(posedge clk) begin
		s2_id <= s1_id;
		for (int a = 0; a < 3; a++) begin
			if (s1_t0[a] < s1_t1[a]) begin
				s2_lo[a] <= s1_t0[a];
				s2_hi[a] <= s1_t1[a];
			end else begin
				s2_lo[a] <= s1_t1[a];
				s2_hi[a] <= s1_t0[a];
			end
		end
	end

	// latest entry, earliest exit
	always_comb begin
		t_near = s2_lo[0];
		t_far = s2_hi[0];
		for (int a = 1; a < 3; a++) begin
			if (s2_lo[a] > t_near) begin
				t_near = s2_lo[a];
			end
			if (s2_hi[a] < t_far) begin
				t_far = s2_hi[a];
			end
		end
	end

	// stage 3: hit decision
	always_ff @(posedge clk) begin
		res.pixel_id <= s2_id;
		res.t_near <= t_near;
		res.hit <= (t_near <= t_far) && (t_far >= fix_t'(0)); // box not behind origin
	end

	assign res_valid = iss_sr[2];

endmodule : slab_intersect

//--- verilog/credit_fifo.sv
// credit_fifo: synchronous circular FIFO for any payload type, reporting its free slots
module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic we,
	input payload_t wdata,
	input logic re,
	output payload_t rdata,
	output logic empty,
	output logic [$clog2(DEPTH+1)-1:0] free
);

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	payload_t mem [DEPTH];
	ptr_t rd_ptr;
	ptr_t wr_ptr;
	cnt_t count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (we) begin
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (re) begin
				rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({we, re})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or simultaneous push/pop
			endcase
		end
	end

	// storage, no reset
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_ptr] <= wdata;
		end
	end

	assign rdata = mem[rd_ptr]; // head entry, valid when !empty
	assign empty = (count == '0);
	assign free = cnt_t'(DEPTH) - count;

endmodule : credit_fifo

//--- verilog/ray_pkg.sv
// ray_pkg: Q8.8 types, scene box, colours and buffer sizing for the ray-casting back end
package ray_pkg;

	localparam int PIX_ID_W = 8;
	localparam int RGB_W = 24;

	// signed Q8.8
	typedef logic signed [15:0] fix_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vec_t;

	typedef struct packed {
		logic [PIX_ID_W-1:0] pixel_id;
		vec_t origin;
		vec_t inv_dir; // 1/dir per axis, from the ray generator
	} ray_t;

	typedef struct packed {
		logic [PIX_ID_W-1:0] pixel_id;
		logic hit;
		fix_t t_near;
	} hit_t;

	typedef struct packed {
		logic [PIX_ID_W-1:0] pixel_id;
		logic [RGB_W-1:0] rgb;
		logic last; // final pixel of a frame
	} pixel_t;

	// unit box, same bounds on all three axes
	localparam fix_t BOX_MIN = 16'sd0;
	localparam fix_t BOX_MAX = 16'sd256;

	localparam logic [RGB_W-1:0] BG_COLOR = 24'h203040;

	localparam int RAY_QUEUE_DEPTH = 4; // also initial ray credits upstream
	localparam int PIX_BUF_DEPTH = 8;
	localparam int PIX_CREDITS = 4; // sink slots after reset
	localparam int FRAME_PIXELS = 16;

	// ray_pop to pixel buffer write: 3 slab stages + 1 shade stage
	localparam int ISSUE_LATENCY = 4;

	localparam int PB_FREE_W = $clog2(PIX_BUF_DEPTH + 1);
	localparam int PIX_CREDIT_W = $clog2(PIX_CREDITS + 1);
	localparam int FRAME_CNT_W = $clog2(FRAME_PIXELS);

endpackage : ray_pkg
